//--- Makefile
# Verilator build, run and lint for the L0 prefetch buffer

VERILATOR ?= verilator
TOP       ?= tb_prefetch_l0_buffer
RTL_TOP   ?= prefetch_l0_buffer
FILELIST  ?= prefetch_l0_buffer.f
RTL_SRCS  ?= prefetch_pkg.sv l0_line_fetch.sv instr_aligner.sv prefetch_l0_buffer.sv
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- instr_aligner.sv
`timescale 1ns/100ps
// core side of the L0 prefetch buffer
// - program counter and parcel selection inside the held line
// - RVC detection on the low two bits of a parcel
// - crossword assembly from a saved parcel and parcel 0 of the next line
// - line requests towards the line fetch unit

module instr_aligner import prefetch_pkg::*; #(
  parameter addr_t RESET_ADDR = '0
) (
  input  logic   clk,
  input  logic   rst_n,

  input  logic   branch_i,
  input  addr_t  branch_addr_i,   // half-word aligned

  // instruction stream to the core
  input  logic   ready_i,
  output logic   valid_o,
  output instr_t instr_o,
  output addr_t  addr_o,

  // line fetch unit
  output logic   line_req_o,
  output addr_t  line_addr_o,
  input  logic   line_valid_i,
  input  line_t  line_data_i
);

  align_state_t state_q, state_n;
  addr_t        pc_q, pc_n;
  addr_t        pc_inc;
  half_t        saved_q;        // low half of a crossword instruction
  logic         save_parcel;
  logic         last_saved_q;   // last consumed instruction was a crossword

  half_t                       halves [HALVES_PER_LINE];
  logic [LINE_OFFSET_BITS-2:0] off;
  logic [LINE_OFFSET_BITS-2:0] off_nxt;
  half_t                       cur_half;
  half_t                       nxt_half;
  logic                        cur_comp;
  logic                        is_cross;
  logic                        use_saved;
  logic                        valid;
  logic                        consume;
  instr_t                      instr;

  //////////////////////////////////////////////////
  // parcel selection
  //////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < HALVES_PER_LINE; i++) begin
      halves[i] = line_data_i[i*HALF_W +: HALF_W];
    end
  end

  assign off      = pc_q[LINE_OFFSET_BITS-1:1];
  assign off_nxt  = off + 1'b1;               // wraps at parcel 7, unused there
  assign cur_half = halves[off];
  assign nxt_half = halves[off_nxt];
  assign cur_comp = cur_half[1:0] != 2'b11;

  assign use_saved = state_q == WAIT_CROSS;
  // 32-bit instruction starting in the last parcel
  assign is_cross  = !use_saved && !cur_comp && (off == '1);

  always_comb begin
    valid = 1'b0;
    instr = {{HALF_W{1'b0}}, cur_half};
    case (state_q)
      WAIT_LINE, STREAM: begin
        valid = line_valid_i && !is_cross;
        if (!cur_comp) begin
          instr = {nxt_half, cur_half};
        end
      end
      WAIT_CROSS: begin
        valid = line_valid_i;
        instr = {halves[0], saved_q};        // upper half from the new line
      end
      default: begin
        valid = 1'b0;
      end
    endcase
  end

  assign valid_o = valid && !branch_i;
  assign instr_o = instr;
  assign addr_o  = pc_q;
  assign consume = valid_o && ready_i;

  assign pc_inc = pc_q + ((use_saved || !cur_comp) ? addr_t'(4) : addr_t'(2));

  assign line_req_o  = state_q != NO_LINE;
  assign line_addr_o = use_saved ? line_base(pc_q) + LINE_BYTES : line_base(pc_q);

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_n     = state_q;
    pc_n        = pc_q;
    save_parcel = 1'b0;

    case (state_q)
      NO_LINE: begin
        state_n = NO_LINE;                   // only a branch leaves
      end

      WAIT_LINE, STREAM: begin
        if (!line_valid_i) begin
          state_n = WAIT_LINE;
        end else if (is_cross) begin
          save_parcel = 1'b1;
          state_n     = WAIT_CROSS;
        end else if (consume) begin
          pc_n    = pc_inc;
          state_n = (line_base(pc_inc) == line_base(pc_q)) ? STREAM : WAIT_LINE;
        end else begin
          state_n = STREAM;
        end
      end

      WAIT_CROSS: begin
        if (consume) begin
          pc_n    = pc_inc;                  // lands inside the new line
          state_n = STREAM;
        end
      end

      default: begin
        state_n = NO_LINE;
      end
    endcase

    // branches always win
    if (branch_i) begin
      pc_n    = branch_addr_i;
      state_n = WAIT_LINE;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= NO_LINE;
      pc_q         <= RESET_ADDR;
      last_saved_q <= 1'b0;
    end else begin
      state_q <= state_n;
      pc_q    <= pc_n;
      if (branch_i) begin
        last_saved_q <= 1'b0;
      end else if (consume) begin
        last_saved_q <= use_saved;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (save_parcel) begin
      saved_q <= cur_half;
    end
  end

  // the core should only be ready while an instruction is offered
  a_ready_valid: assert property (
    @(posedge clk) disable iff (!rst_n || branch_i)
    ready_i |-> valid_o)
    else $error("ready_i without valid_o from the prefetch buffer");

  // no two crossword outputs back to back
  a_no_double_cross: assert property (
    @(posedge clk) disable iff (!rst_n)
    (consume && use_saved) |-> !last_saved_q)
    else $error("saved parcel used for two instructions in a row");

endmodule

//--- l0_line_fetch.sv
`timescale 1ns/100ps
// memory side of the L0 prefetch buffer
// - req/gnt/rvalid FSM fetching one 16-byte line at a time
// - single outstanding request, last line kept for hits
// - stale responses dropped after a branch

module l0_line_fetch import prefetch_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,

  input  logic  branch_i,
  input  logic  line_req_i,       // held while the aligner needs line_addr_i
  input  addr_t line_addr_i,
  output logic  line_valid_o,
  output line_t line_data_o,

  // instruction memory port
  output logic  instr_req_o,
  output addr_t instr_addr_o,
  input  logic  instr_gnt_i,
  input  logic  instr_rvalid_i,
  input  line_t instr_rdata_i,

  output logic  busy_o
);

  fetch_state_t state_q, state_n;
  addr_t        addr_q;      // line address of the last request
  line_t        line_q;      // last line received
  logic         abort_q;     // branch seen while waiting for the grant
  logic         abort_n;
  logic         tag_hit;
  logic         resp_ok;     // response accepted this cycle
  logic         issue;       // new request from EMPTY or LINE_VALID

  assign tag_hit = addr_q == line_base(line_addr_i);
  assign resp_ok = (state_q == WAIT_RVALID) && instr_rvalid_i && !branch_i;

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_n     = state_q;
    abort_n     = 1'b0;
    issue       = 1'b0;
    instr_req_o = 1'b0;

    case (state_q)
      EMPTY, LINE_VALID: begin
        // no request in a branch cycle, the pc is not updated yet
        if (line_req_i && !branch_i && !(state_q == LINE_VALID && tag_hit)) begin
          issue       = 1'b1;
          instr_req_o = 1'b1;
          state_n     = instr_gnt_i ? WAIT_RVALID : WAIT_GNT;
        end
      end

      WAIT_GNT: begin
        instr_req_o = 1'b1;              // must stay up until granted
        abort_n     = abort_q || branch_i;
        if (instr_gnt_i) begin
          state_n = abort_n ? ABORTED : WAIT_RVALID;
          abort_n = 1'b0;
        end
      end

      WAIT_RVALID: begin
        if (branch_i) begin
          state_n = instr_rvalid_i ? EMPTY : ABORTED;
        end else if (instr_rvalid_i) begin
          state_n = LINE_VALID;
        end
      end

      ABORTED: begin
        if (instr_rvalid_i) begin
          state_n = EMPTY;             // stale line, thrown away
        end
      end

      default: begin
        state_n = EMPTY;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= EMPTY;
      abort_q <= 1'b0;
      addr_q  <= '0;
    end else begin
      state_q <= state_n;
      abort_q <= abort_n;
      if (issue) begin
        addr_q <= line_base(line_addr_i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (resp_ok) begin
      line_q <= instr_rdata_i;
    end
  end

  //////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////

  assign instr_addr_o = issue ? line_base(line_addr_i) : addr_q;

  // the response line is forwarded in its own cycle
  assign line_data_o  = resp_ok ? instr_rdata_i : line_q;

  assign line_valid_o = line_req_i && tag_hit && !branch_i &&
                        (resp_ok || (state_q == LINE_VALID));

  assign busy_o = !((state_q == EMPTY) || (state_q == LINE_VALID));

  // request and address hold until the memory grants
  a_req_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (instr_req_o && !instr_gnt_i) |=> (instr_req_o && $stable(instr_addr_o)))
    else $error("instruction request dropped or changed before grant");

  // responses only come for a granted request
  a_rvalid_state: assert property (
    @(posedge clk) disable iff (!rst_n)
    instr_rvalid_i |-> (state_q inside {WAIT_RVALID, ABORTED}))
    else $error("instr_rvalid_i without an outstanding request");

endmodule

//--- prefetch_l0_buffer.f
prefetch_pkg.sv
l0_line_fetch.sv
instr_aligner.sv
prefetch_l0_buffer.sv
tb_imem.sv
tb_prefetch_l0_buffer.sv

//--- prefetch_l0_buffer.sv
`timescale 1ns/100ps
// L0 instruction prefetch buffer, top level
// - line fetch unit on the 128-bit instruction memory port
// - aligner handing out 16/32-bit instructions to the core

module prefetch_l0_buffer import prefetch_pkg::*; #(
  parameter addr_t RESET_ADDR = 32'h0000_0080    // pc after reset
) (
  input  logic   clk,
  input  logic   rst_n,

  // core side
  input  logic   branch_i,
  input  addr_t  branch_addr_i,
  input  logic   ready_i,
  output logic   valid_o,
  output instr_t instr_o,
  output addr_t  addr_o,

  // instruction memory
  output logic   instr_req_o,
  output addr_t  instr_addr_o,
  input  logic   instr_gnt_i,
  input  logic   instr_rvalid_i,
  input  line_t  instr_rdata_i,

  output logic   busy_o
);

  logic  line_req;
  addr_t line_addr;
  logic  line_valid;
  line_t line_data;

  //////////////////////////////////////////////////
  // memory side
  //////////////////////////////////////////////////

  l0_line_fetch l0_line_fetch_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .branch_i       (branch_i),      // aborts an outstanding response
    .line_req_i     (line_req),
    .line_addr_i    (line_addr),
    .line_valid_o   (line_valid),
    .line_data_o    (line_data),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .busy_o         (busy_o)
  );

  //////////////////////////////////////////////////
  // core side
  //////////////////////////////////////////////////

  instr_aligner #(
    .RESET_ADDR (RESET_ADDR)
  ) instr_aligner_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .ready_i       (ready_i),
    .valid_o       (valid_o),
    .instr_o       (instr_o),
    .addr_o        (addr_o),
    .line_req_o    (line_req),
    .line_addr_o   (line_addr),
    .line_valid_i  (line_valid),
    .line_data_i   (line_data)
  );

endmodule

//--- prefetch_pkg.sv
// shared definitions for the L0 instruction prefetch buffer
// - bus and instruction widths
// - typedefs for addresses, instruction slots, parcels and lines
// - line geometry constants and a line base helper
// - state enums of the aligner and the line fetch unit

package prefetch_pkg;

  //////////////////////////////////////////////////
  // widths and line geometry
  //////////////////////////////////////////////////

  localparam int unsigned ADDR_W           = 32;
  localparam int unsigned INSTR_W          = 32;
  localparam int unsigned HALF_W           = 16;  // one RVC parcel
  localparam int unsigned LINE_BYTES       = 16;
  localparam int unsigned LINE_W           = LINE_BYTES * 8;
  localparam int unsigned HALVES_PER_LINE  = 8;
  localparam int unsigned LINE_OFFSET_BITS = 4;   // byte offset inside a line

  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [INSTR_W-1:0] instr_t;  // compressed ones are zero extended
  typedef logic [HALF_W-1:0]  half_t;
  typedef logic [LINE_W-1:0]  line_t;   // parcel 0 in the low bits

  //////////////////////////////////////////////////
  // state machines
  //////////////////////////////////////////////////

  typedef enum logic [3:0] {
    NO_LINE,     // idle until the first branch
    WAIT_LINE,   // waiting for the line holding the pc
    STREAM,      // line held, handing out instructions
    WAIT_CROSS   // low half saved, waiting for the next line
  } align_state_t;

  typedef enum logic [2:0] {
    EMPTY,
    WAIT_GNT,
    WAIT_RVALID,
    LINE_VALID,
    ABORTED      // granted response must be dropped
  } fetch_state_t;

  // address of the first byte of the line holding addr
  function automatic addr_t line_base(addr_t addr);
    return {addr[ADDR_W-1:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}};
  endfunction

endpackage

//--- tb_imem.sv
`timescale 1ns/100ps
// instruction memory model for the prefetch buffer testbench
// - grant after 0 to 3 cycles of a pending request
// - response 0 to 3 cycles after the first possible cycle, one outstanding
// - line content as a fixed function of the parcel address

module tb_imem import prefetch_pkg::*; #(
  parameter logic [31:0] SEED = 32'd69287
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  req_i,
  input  addr_t addr_i,
  output logic  gnt_o,
  output logic  rvalid_o,
  output line_t rdata_o
);

  logic [31:0] rng;
  logic        pending;     // granted, response not sent yet
  logic [1:0]  gnt_wait;
  logic [1:0]  rsp_wait;
  addr_t       pend_addr;
  addr_t       addr_seen;
  logic        req_seen;
  logic        took;        // handshake completes at the next edge

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // about half of the parcels open a 32-bit instruction
  function automatic half_t parcel_at(input addr_t a);
    logic [31:0] h;
    h = {a[31:1], 1'b0} * 32'h9e37_79b1;
    h = h ^ (h >> 15);
    return {h[31:18], (h[9] ? 2'b11 : {1'b0, h[10]})};
  endfunction

  function automatic line_t line_at(input addr_t base);
    line_t l;
    for (int i = 0; i < HALVES_PER_LINE; i++) begin
      l[i*HALF_W +: HALF_W] = parcel_at(base + addr_t'(2 * i));
    end
    return l;
  endfunction

  initial begin
    gnt_o     = 1'b0;
    rvalid_o  = 1'b0;
    rdata_o   = '0;
    rng       = SEED;
    pending   = 1'b0;
    gnt_wait  = 2'd0;
    rsp_wait  = 2'd0;
    pend_addr = '0;
  end

  always begin
    @(negedge clk);
    took      = req_i && gnt_o;
    req_seen  = req_i;
    addr_seen = addr_i;
    @(posedge clk);
    #0.5;                                    // ahead of the core side inputs
    rvalid_o = 1'b0;
    if (!rst_n) begin
      gnt_o   = 1'b0;
      pending = 1'b0;
    end else if (took) begin
      gnt_o     = 1'b0;
      pend_addr = addr_seen;
      rng       = lcg_next(rng);
      rsp_wait  = rng[17:16];
      pending   = 1'b1;
    end else if (pending) begin
      if (rsp_wait == 2'd0) begin
        rvalid_o = 1'b1;
        rdata_o  = line_at(pend_addr);
        pending  = 1'b0;
        rng      = lcg_next(rng);
        gnt_wait = rng[17:16];
        gnt_o    = gnt_wait == 2'd0;         // next request granted at once
      end else begin
        rsp_wait = rsp_wait - 2'd1;
      end
    end else if (req_seen && !gnt_o) begin
      if (gnt_wait == 2'd0) begin
        gnt_o = 1'b1;
      end else begin
        gnt_wait = gnt_wait - 2'd1;
      end
    end
  end

endmodule

//--- tb_prefetch_l0_buffer.sv
`timescale 1ns/100ps
// testbench for the L0 instruction prefetch buffer
// - clock, reset and LCG driven branches and ready
// - reference model decoding memory parcels from the last branch target
// - memory port checks and watchdog

module tb_prefetch_l0_buffer import prefetch_pkg::*; ();

  localparam int unsigned NUM_TESTS    = 600;   // instructions to consume
  localparam int unsigned RESET_CYC    = 16;
  localparam int unsigned WATCHDOG_CYC = NUM_TESTS * 40;
  localparam logic [31:0] LCG_SEED     = 32'd69287;

  logic   clk;
  logic   rst_n;
  logic   branch;
  addr_t  branch_addr;
  logic   ready;
  logic   valid;
  instr_t instr;
  addr_t  addr;
  logic   instr_req;
  addr_t  instr_addr;
  logic   instr_gnt;
  logic   instr_rvalid;
  line_t  instr_rdata;
  logic   busy;

  logic [31:0] rng;
  addr_t       model_pc;      // address of the next expected instruction
  logic        held;          // offered but not consumed last cycle
  logic        started;
  logic        outstanding = 1'b0;
  int unsigned consumed;
  int unsigned cross_cnt;
  int unsigned abort_cnt;

  prefetch_l0_buffer prefetch_l0_buffer_i (
    .clk (clk), .rst_n (rst_n),
    .branch_i (branch), .branch_addr_i (branch_addr), .ready_i (ready),
    .valid_o (valid), .instr_o (instr), .addr_o (addr),
    .instr_req_o (instr_req), .instr_addr_o (instr_addr), .instr_gnt_i (instr_gnt),
    .instr_rvalid_i (instr_rvalid), .instr_rdata_i (instr_rdata), .busy_o (busy)
  );

  tb_imem #(.SEED (LCG_SEED)) imem_i (
    .clk (clk), .rst_n (rst_n), .req_i (instr_req), .addr_i (instr_addr),
    .gnt_o (instr_gnt), .rvalid_o (instr_rvalid), .rdata_o (instr_rdata)
  );

  always #4 clk = ~clk;

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic abort_run();
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic report_problem(input string what);
    $display("%s at %0t", what, $time);
    abort_run();
  endtask

  task automatic check_instr(input instr_t got_i, input addr_t got_a,
                             input instr_t exp_i, input addr_t exp_a);
    if (got_i !== exp_i || got_a !== exp_a) begin
      $display("Fail at %0t: instruction %h at %h, expected %h at %h",
               $time, got_i, got_a, exp_i, exp_a);
      abort_run();
    end
  endtask

  task automatic check_line_addr(input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("Fail at %0t: line request at %h, expected %h", $time, got, exp);
      abort_run();
    end
  endtask

  // RVC rule: low bits 11 means a 32-bit instruction
  task automatic decode_at(input addr_t pc, output instr_t ins, output addr_t next_pc);
    half_t lo;
    lo = imem_i.parcel_at(pc);
    if (lo[1:0] == 2'b11) begin
      ins     = {imem_i.parcel_at(pc + 32'd2), lo};
      next_pc = pc + 32'd4;
    end else begin
      ins     = {16'h0000, lo};
      next_pc = pc + 32'd2;
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus and reference model
  //////////////////////////////////////////////////

  initial begin
    instr_t exp_instr;
    addr_t  next_pc;
    addr_t  exp_line;
    logic   req_prev;
    logic   take_branch;
    logic   want_ready;
    clk         = 1'b0;
    rst_n       = 1'b0;
    branch      = 1'b0;
    branch_addr = '0;
    ready       = 1'b0;
    rng         = LCG_SEED;
    model_pc    = '0;
    held        = 1'b0;
    started     = 1'b0;
    req_prev    = 1'b0;
    consumed    = 0;
    cross_cnt   = 0;
    abort_cnt   = 0;
    repeat (RESET_CYC) @(posedge clk);
    #1 rst_n = 1'b1;
    repeat (4) begin
      @(negedge clk);
      if (valid || instr_req || busy) report_problem("DUT active before the first branch");
    end

    while (consumed < NUM_TESTS) begin
      @(posedge clk);
      #1;
      rng         = lcg_next(rng);
      take_branch = !started || (rng[29:25] == 5'd0);
      want_ready  = rng[19:18] != 2'd0;
      if (take_branch && busy) abort_cnt++;         // fetch in flight
      ready       = want_ready && valid && !take_branch;
      branch      = take_branch;
      if (take_branch) branch_addr = addr_t'(32'h1000) + addr_t'({rng[16:8], 1'b0});
      @(negedge clk);
      // a new request fetches the line that the stream needs next
      if (instr_req && !req_prev) begin
        decode_at(model_pc, exp_instr, next_pc);
        exp_line = {model_pc[31:4], 4'h0};
        if (model_pc[3:1] == 3'd7 && exp_instr[1:0] == 2'b11 &&
            instr_addr[31:4] != model_pc[31:4]) begin
          exp_line = exp_line + 32'd16;     // upper half of a crossword
        end
        check_line_addr(instr_addr, exp_line);
      end
      req_prev = instr_req;
      if (branch) begin
        if (valid) report_problem("valid_o high in a branch cycle");
        model_pc = branch_addr;
        held     = 1'b0;
        started  = 1'b1;
      end else if (valid) begin
        decode_at(model_pc, exp_instr, next_pc);
        check_instr(instr, addr, exp_instr, model_pc);
        if (ready) begin
          if (model_pc[3:1] == 3'd7 && exp_instr[1:0] == 2'b11) cross_cnt++;
          model_pc = next_pc;
          held     = 1'b0;
          consumed++;
        end else begin
          held = 1'b1;
        end
      end else if (held) begin
        report_problem("valid_o dropped before the instruction was consumed");
      end
    end

    $display("%0d instructions, %0d crosswords, %0d branches during a fetch",
             consumed, cross_cnt, abort_cnt);
    if (cross_cnt > 0 && abort_cnt > 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("stream never hit a crossword instruction or a branch during a fetch");
      abort_run();
    end
  end

  // memory port rules, away from the clock edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (instr_req && outstanding) report_problem("line request before the previous response");
      if (!instr_req && busy !== outstanding) begin
        report_problem("busy_o does not follow the fetch in flight");
      end
      if (instr_req && instr_gnt) outstanding = 1'b1;
      if (instr_rvalid) outstanding = 1'b0;
    end
  end

  initial begin
    repeat (RESET_CYC + WATCHDOG_CYC) @(posedge clk);
    $display("timeout after %0d cycles, the instruction stream stalled", WATCHDOG_CYC);
    abort_run();
  end

endmodule
